// File: run_sim.sh
#!/bin/sh
# build and run the iq capture testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f sim.f \
	--top-module tb_side_ch_iq_capture -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim.f
source/side_ch_pkg.sv
source/iq_trigger.sv
source/iq_ring_buffer.sv
source/iq_capture_seq.sv
source/dma_stream_select.sv
source/side_ch_iq_capture.sv
+incdir+test
test/tb_side_ch_iq_capture.sv

// File: source/dma_stream_select.sv
// dma stream select, picks loopback or capture stream and the dma start pulse
`timescale 1ns/10ps

module dma_stream_select (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic [1:0]             start_mode,
	input  logic                   ext_start,
	input  logic                   reg_wren,
	input  logic [4:0]             reg_waddr,
	input  side_ch_pkg::dma_word_t lb_data,
	input  logic                   lb_valid,
	input  logic                   lb_last,
	input  side_ch_pkg::dma_word_t cap_word,
	input  logic                   cap_valid,
	output side_ch_pkg::dma_word_t data_to_ps,
	output logic                   data_to_ps_valid,
	output logic                   m_axis_start_1trans,
	output logic                   pl_ask_data
);

	logic len_wr_d1;
	logic len_wr_d2;
	logic auto_start;

	// dma length register is register 2
	always_ff @(posedge clk) begin
		if (!rstn) begin
			len_wr_d1 <= 1'b0;
			len_wr_d2 <= 1'b0;
		end else begin
			len_wr_d1 <= reg_wren && (reg_waddr == 5'd2);
			len_wr_d2 <= len_wr_d1;
		end
	end

	assign auto_start = len_wr_d1 && !len_wr_d2; // rising edge only

	always_comb begin
		case (start_mode)
			2'd0: begin // loopback of host stream
				m_axis_start_1trans = lb_last;
				data_to_ps          = lb_data;
				data_to_ps_valid    = lb_valid;
				pl_ask_data         = 1'b1;
			end
			2'd1: begin
				m_axis_start_1trans = auto_start;
				data_to_ps          = cap_word;
				data_to_ps_valid    = cap_valid;
				pl_ask_data         = 1'b0;
			end
			2'd2: begin
				m_axis_start_1trans = ext_start;
				data_to_ps          = cap_word;
				data_to_ps_valid    = cap_valid;
				pl_ask_data         = 1'b0;
			end
			default: begin // all off
				m_axis_start_1trans = 1'b0;
				data_to_ps          = '0;
				data_to_ps_valid    = 1'b0;
				pl_ask_data         = 1'b0;
			end
		endcase
	end

endmodule

// File: source/iq_capture_seq.sv
// iq capture sequencer, locks tsf on trigger and streams header plus buffered pairs
`timescale 1ns/10ps

module iq_capture_seq #(
	parameter int BUF_ADDR_WIDTH  = 10,
	parameter int DMA_COUNT_WIDTH = 14
) (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic                       iq_trigger,
	input  logic                       iq_strobe,
	input  logic [BUF_ADDR_WIDTH-1:0]  wr_ptr,
	output logic [BUF_ADDR_WIDTH-1:0]  rd_addr,
	input  side_ch_pkg::iq_pair_t      rd_data,
	input  side_ch_pkg::tsf_t          tsf_runtime_val,
	input  logic [BUF_ADDR_WIDTH-1:0]  pre_trigger_len,
	input  logic [BUF_ADDR_WIDTH-1:0]  iq_len_target,
	input  logic [DMA_COUNT_WIDTH-1:0] m_axis_data_count,
	output side_ch_pkg::dma_word_t     cap_word,
	output logic                       cap_valid
);

	typedef enum logic [1:0] {
		WAIT,
		PREPARE,
		HEADER,
		STREAM
	} seq_state_e;

	seq_state_e                state;
	side_ch_pkg::tsf_t         tsf_lock;
	logic [BUF_ADDR_WIDTH-1:0] iq_count;
	logic                      space_ok;

	// free fifo space must hold header plus all samples
	assign space_ok = (side_ch_pkg::UDP_MAX_SYMBOL - int'(m_axis_data_count))
		>= (int'(iq_len_target) + 1);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state     <= WAIT;
			rd_addr   <= '0;
			iq_count  <= '0;
			cap_valid <= 1'b0;
		end else begin
			case (state)
				WAIT: begin
					cap_valid <= 1'b0;
					iq_count  <= '0;
					if (iq_trigger) begin
						rd_addr <= wr_ptr - pre_trigger_len; // back up into history
						state   <= PREPARE;
					end
				end
				PREPARE: begin
					state <= space_ok ? HEADER : WAIT; // no room, drop this trigger
				end
				HEADER: begin
					cap_valid <= 1'b1;
					state     <= (iq_len_target == '0) ? WAIT : STREAM;
				end
				STREAM: begin
					cap_valid <= iq_strobe;
					if (iq_strobe) begin
						rd_addr  <= rd_addr + 1'b1;
						iq_count <= iq_count + 1'b1;
						if (iq_count == iq_len_target - 1'b1)
							state <= WAIT; // last sample goes out now
					end
				end
				default: state <= WAIT;
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (state == WAIT && iq_trigger)
			tsf_lock <= tsf_runtime_val;
		if (state == HEADER)
			cap_word <= tsf_lock;
		else if (state == STREAM)
			cap_word <= rd_data; // word from previous read address
	end

endmodule

// File: source/iq_ring_buffer.sv
// iq ring buffer, circular pair memory with wrapping write pointer and registered read
`timescale 1ns/10ps

module iq_ring_buffer #(
	parameter int BUF_ADDR_WIDTH = 10
) (
	input  logic                      clk,
	input  logic                      rstn,
	input  side_ch_pkg::iq_pair_t     wr_data,
	input  logic                      wr_en,
	output logic [BUF_ADDR_WIDTH-1:0] wr_ptr,
	input  logic [BUF_ADDR_WIDTH-1:0] rd_addr,
	output side_ch_pkg::iq_pair_t     rd_data
);

	localparam int DEPTH = 2 ** BUF_ADDR_WIDTH;

	side_ch_pkg::iq_pair_t mem [DEPTH];

	// pointer wraps by overflow
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // one clock read latency
	end

endmodule

// File: source/iq_trigger.sv
// iq trigger unit, turns receiver events into the selected one-cycle trigger pulse
`timescale 1ns/10ps

module iq_trigger (
	input  logic                     clk,
	input  logic                     rstn,
	input  side_ch_pkg::rx_events_t  rx_ev,
	input  side_ch_pkg::trig_sel_e   trig_sel,
	input  side_ch_pkg::rssi_t       rssi_th,
	input  logic [6:0]               gain_th,
	output logic                     iq_trigger
);

	side_ch_pkg::rssi_t        rssi_reg;
	side_ch_pkg::gpio_status_t gpio_reg;

	logic rssi_rise;
	logic rssi_fall;
	logic agc_unlock;
	logic agc_lock;
	logic gain_rise;

	// previous-cycle copies and edge detection against them
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_reg   <= '0;
			gpio_reg   <= '0;
			rssi_rise  <= 1'b0;
			rssi_fall  <= 1'b0;
			agc_unlock <= 1'b0;
			agc_lock   <= 1'b0;
			gain_rise  <= 1'b0;
		end else begin
			rssi_reg <= rx_ev.rssi;
			gpio_reg <= rx_ev.gpio_status;

			// threshold crossings, signed compare
			rssi_rise <= (rssi_reg < rssi_th) && (rx_ev.rssi >= rssi_th);
			rssi_fall <= (rssi_reg >= rssi_th) && (rx_ev.rssi < rssi_th);

			agc_unlock <= gpio_reg[7] && !rx_ev.gpio_status[7];
			agc_lock   <= !gpio_reg[7] && rx_ev.gpio_status[7];

			gain_rise <= (gpio_reg[6:0] < gain_th) && (rx_ev.gpio_status[6:0] >= gain_th);
		end
	end

	// fcs events go straight in, level events are one cycle later
	always_ff @(posedge clk) begin
		if (!rstn) begin
			iq_trigger <= 1'b0;
		end else begin
			case (trig_sel)
				side_ch_pkg::FCS_ANY:
					iq_trigger <= rx_ev.fcs_in_strobe || rx_ev.free_run;
				side_ch_pkg::FCS_GOOD:
					iq_trigger <= rx_ev.fcs_in_strobe && rx_ev.fcs_ok;
				side_ch_pkg::FCS_BAD:
					iq_trigger <= rx_ev.fcs_in_strobe && !rx_ev.fcs_ok;
				side_ch_pkg::RSSI_RISE:  iq_trigger <= rssi_rise;
				side_ch_pkg::RSSI_FALL:  iq_trigger <= rssi_fall;
				side_ch_pkg::AGC_UNLOCK: iq_trigger <= agc_unlock;
				side_ch_pkg::AGC_LOCK:   iq_trigger <= agc_lock;
				side_ch_pkg::GAIN_RISE:  iq_trigger <= gain_rise;
				default:                 iq_trigger <= 1'b0;
			endcase
		end
	end

endmodule

// File: source/side_ch_iq_capture.sv
// side channel iq capture top, trigger, ring buffer, sequencer and dma stream select
`timescale 1ns/10ps

module side_ch_iq_capture #(
	parameter int BUF_ADDR_WIDTH  = 10,
	parameter int DMA_COUNT_WIDTH = 14
) (
	input  logic                       clk,
	input  logic                       rstn,
	// receiver side
	input  side_ch_pkg::rx_events_t    rx_ev,
	input  side_ch_pkg::iq_pair_t      iq_in,
	input  logic                       iq_strobe,
	input  side_ch_pkg::tsf_t          tsf_runtime_val,
	// host configuration
	input  side_ch_pkg::trig_sel_e     trig_sel,
	input  side_ch_pkg::rssi_t         rssi_th,
	input  logic [6:0]                 gain_th,
	input  logic [BUF_ADDR_WIDTH-1:0]  pre_trigger_len,
	input  logic [BUF_ADDR_WIDTH-1:0]  iq_len_target,
	input  logic [1:0]                 start_mode,
	input  logic                       ext_start,
	input  logic                       reg_wren,
	input  logic [4:0]                 reg_waddr,
	// host to pl loopback stream
	input  side_ch_pkg::dma_word_t     lb_data,
	input  logic                       lb_valid,
	input  logic                       lb_last,
	// toward host dma
	input  logic [DMA_COUNT_WIDTH-1:0] m_axis_data_count,
	output side_ch_pkg::dma_word_t     data_to_ps,
	output logic                       data_to_ps_valid,
	output logic                       m_axis_start_1trans,
	output logic                       pl_ask_data
);

	logic                      iq_trigger;
	logic [BUF_ADDR_WIDTH-1:0] wr_ptr;
	logic [BUF_ADDR_WIDTH-1:0] rd_addr;
	side_ch_pkg::iq_pair_t     rd_data;
	side_ch_pkg::dma_word_t    cap_word;
	logic                      cap_valid;

	iq_trigger iq_trigger_i (
		.clk        (clk),
		.rstn       (rstn),
		.rx_ev      (rx_ev),
		.trig_sel   (trig_sel),
		.rssi_th    (rssi_th),
		.gain_th    (gain_th),
		.iq_trigger (iq_trigger)
	);

	iq_ring_buffer #(
		.BUF_ADDR_WIDTH (BUF_ADDR_WIDTH)
	) iq_ring_buffer_i (
		.clk     (clk),
		.rstn    (rstn),
		.wr_data (iq_in),
		.wr_en   (iq_strobe),
		.wr_ptr  (wr_ptr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	iq_capture_seq #(
		.BUF_ADDR_WIDTH  (BUF_ADDR_WIDTH),
		.DMA_COUNT_WIDTH (DMA_COUNT_WIDTH)
	) iq_capture_seq_i (
		.clk               (clk),
		.rstn              (rstn),
		.iq_trigger        (iq_trigger),
		.iq_strobe         (iq_strobe),
		.wr_ptr            (wr_ptr),
		.rd_addr           (rd_addr),
		.rd_data           (rd_data),
		.tsf_runtime_val   (tsf_runtime_val),
		.pre_trigger_len   (pre_trigger_len),
		.iq_len_target     (iq_len_target),
		.m_axis_data_count (m_axis_data_count),
		.cap_word          (cap_word),
		.cap_valid         (cap_valid)
	);

	dma_stream_select dma_stream_select_i (
		.clk                 (clk),
		.rstn                (rstn),
		.start_mode          (start_mode),
		.ext_start           (ext_start),
		.reg_wren            (reg_wren),
		.reg_waddr           (reg_waddr),
		.lb_data             (lb_data),
		.lb_valid            (lb_valid),
		.lb_last             (lb_last),
		.cap_word            (cap_word),
		.cap_valid           (cap_valid),
		.data_to_ps          (data_to_ps),
		.data_to_ps_valid    (data_to_ps_valid),
		.m_axis_start_1trans (m_axis_start_1trans),
		.pl_ask_data         (pl_ask_data)
	);

endmodule

// File: source/side_ch_pkg.sv
// side channel iq capture shared types, sample and event structs and trigger codes
package side_ch_pkg;

	// largest number of 64-bit words in one UDP transfer (65507 bytes / 8)
	parameter integer UDP_MAX_SYMBOL = 8188;

	typedef logic [31:0] iq_t;              // q in [31:16], i in [15:0]
	typedef logic [63:0] dma_word_t;
	typedef logic [63:0] tsf_t;             // 802.11 timer
	typedef logic signed [10:0] rssi_t;     // half dB steps
	typedef logic [7:0] gpio_status_t;      // [7] agc lock, [6:0] gain

	// buffer word, antenna 1 in the upper half
	typedef struct packed {
		iq_t iq1;
		iq_t iq0;
	} iq_pair_t;

	// receiver events seen by the trigger unit
	typedef struct packed {
		logic         fcs_in_strobe;
		logic         fcs_ok;
		logic         free_run;
		rssi_t        rssi;
		gpio_status_t gpio_status;
	} rx_events_t;

	typedef enum logic [2:0] {
		FCS_ANY    = 3'd0, // any fcs strobe, or free run
		FCS_GOOD   = 3'd1,
		FCS_BAD    = 3'd2,
		RSSI_RISE  = 3'd3,
		RSSI_FALL  = 3'd4,
		AGC_UNLOCK = 3'd5, // lock to unlock
		AGC_LOCK   = 3'd6,
		GAIN_RISE  = 3'd7
	} trig_sel_e;

endpackage

// File: test/tb_ref_model.svh
// iq capture testbench reference model with pair history, expected words and compare tasks
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

side_ch_pkg::iq_pair_t history[$]; // strobed pairs, index is the strobe count
string cur_test = "reset";
int err_count = 0;
int errs_before = 0;
int test_count = 0;
int failed_tests = 0;

// expected word idx of a capture, locked tsf at idx 0 and pairs from count - pre after it
function automatic side_ch_pkg::dma_word_t expected_word(input int idx,
		input side_ch_pkg::tsf_t tsf, input int count, input int pre);
	if (idx == 0)
		return tsf;
	return history[count - pre + idx - 1];
endfunction

task automatic check_word(input string what, input side_ch_pkg::dma_word_t exp,
		input side_ch_pkg::dma_word_t got);
	if (got !== exp) begin
		$display("** Error: %s, %s: expected %h, actual %h", cur_test, what, exp, got);
		err_count++;
	end
endtask

task automatic check_bit(input string what, input logic exp, input logic got);
	if (got !== exp) begin
		$display("** Error: %s, %s: expected %b, actual %b", cur_test, what, exp, got);
		err_count++;
	end
endtask

task automatic begin_test(input string name);
	cur_test = name;
	errs_before = err_count;
endtask

task automatic end_test();
	test_count++;
	if (err_count == errs_before) begin
		$display("%s: ok", cur_test);
	end else begin
		failed_tests++;
		$display("%s: %0d errors", cur_test, err_count - errs_before);
	end
endtask

`endif

// File: test/tb_side_ch_iq_capture.sv
// testbench for the side channel iq capture, loopback, trigger captures, back-pressure, auto start
`timescale 1ns/10ps

module tb_side_ch_iq_capture;

	localparam int ADDR_W = 6;
	localparam int CNT_W  = 14;
	localparam int PRE    = 4; // pre-trigger samples
	localparam int LEN    = 8; // samples per capture
	localparam int PAUSE  = 12;

	logic clk;
	logic rstn;
	side_ch_pkg::rx_events_t rx_ev;
	side_ch_pkg::iq_pair_t iq_in;
	side_ch_pkg::tsf_t tsf_runtime_val;
	side_ch_pkg::trig_sel_e trig_sel;
	side_ch_pkg::rssi_t rssi_th;
	logic [6:0] gain_th;
	logic [ADDR_W-1:0] pre_trigger_len;
	logic [ADDR_W-1:0] iq_len_target;
	logic [1:0] start_mode;
	logic [4:0] reg_waddr;
	logic iq_strobe;
	logic ext_start;
	logic reg_wren;
	logic lb_valid;
	logic lb_last;
	side_ch_pkg::dma_word_t lb_data;
	logic [CNT_W-1:0] m_axis_data_count;
	side_ch_pkg::dma_word_t data_to_ps;
	logic data_to_ps_valid;
	logic m_axis_start_1trans;
	logic pl_ask_data;

	side_ch_pkg::dma_word_t exp_q[$]; // loopback words still due on data_to_ps
	side_ch_pkg::dma_word_t exp_word;
	side_ch_pkg::tsf_t tsf_now;
	int phase = 0;

	// capture in flight, words are derived when they arrive
	int cap_left = 0;
	int cap_idx = 0;
	int cap_count = 0;
	side_ch_pkg::tsf_t cap_tsf;

	`include "tb_ref_model.svh"

	side_ch_iq_capture #(
		.BUF_ADDR_WIDTH  (ADDR_W),
		.DMA_COUNT_WIDTH (CNT_W)
	) side_ch_iq_capture_i (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic side_ch_pkg::rx_events_t make_events(input logic strobe, input logic ok,
			input int rssi);
		side_ch_pkg::rx_events_t ev;
		ev = '0;
		ev.fcs_in_strobe = strobe;
		ev.fcs_ok = ok;
		ev.rssi = side_ch_pkg::rssi_t'(rssi);
		return ev;
	endfunction

	// tsf ticks every cycle and a new pair comes every fifth cycle
	task automatic run_cycle();
		side_ch_pkg::iq_pair_t pair;
		@(posedge clk);
		phase = (phase + 1) % 5;
		tsf_now = tsf_now + 64'd1;
		tsf_runtime_val <= tsf_now;
		if (phase == 0) begin
			pair.iq0 = $urandom;
			pair.iq1 = $urandom;
			history.push_back(pair);
			iq_in <= pair;
		end
		iq_strobe <= (phase == 0);
	endtask

	task automatic run_cycles(input int n);
		repeat (n) run_cycle();
	endtask

	task automatic hold_cycle(); // strobes and tsf frozen
		@(posedge clk);
		iq_strobe <= 1'b0;
	endtask

	// quiet window around one receiver event
	task automatic fire_event(input side_ch_pkg::rx_events_t ev, input logic expect_cap);
		side_ch_pkg::rx_events_t ev_after;
		repeat (3) hold_cycle();
		if (expect_cap) begin
			cap_tsf = tsf_now;
			cap_count = history.size();
			cap_idx = 0;
			cap_left = LEN + 1; // header plus samples
		end
		hold_cycle();
		rx_ev <= ev;
		ev_after = ev;
		ev_after.fcs_in_strobe = 1'b0; // fcs strobe for one cycle only
		hold_cycle();
		rx_ev <= ev_after;
		repeat (PAUSE - 5) hold_cycle();
	endtask

	task automatic wait_drain(input int limit);
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || cap_left != 0) && waited < limit) begin
			run_cycle();
			waited++;
		end
		if (exp_q.size() != 0 || cap_left != 0) begin
			$display("%s: timed out with %0d expected words never seen", cur_test,
				exp_q.size() + cap_left);
			err_count++;
			exp_q.delete();
			cap_left = 0;
		end
		run_cycles(20); // room for stray extra words
	endtask

	task automatic reg_write_check(input logic [4:0] addr, input logic expect_pulse);
		int k;
		for (k = 0; k < 8; k++) begin
			hold_cycle();
			reg_wren <= (k == 0);
			reg_waddr <= addr;
			@(negedge clk);
			check_bit("start pulse", expect_pulse && (k == 1), m_axis_start_1trans);
		end
	endtask

	// every valid word is checked against the words still due
	always @(negedge clk) begin
		if (rstn && data_to_ps_valid) begin
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				check_word("data_to_ps", exp_word, data_to_ps);
			end else if (cap_left != 0) begin
				exp_word = expected_word(cap_idx, cap_tsf, cap_count, PRE);
				check_word("data_to_ps", exp_word, data_to_ps);
				cap_idx++;
				cap_left--;
			end else begin
				$display("%s: data_to_ps valid with no word expected (%h)", cur_test, data_to_ps);
				err_count++;
			end
		end
	end

	initial begin : main
		int i;
		side_ch_pkg::dma_word_t lb_word;
		void'($urandom(32'h512d_e681));
		tsf_now = 64'h0000_00a5_0000_0000;
		rstn = 1'b0;
		rx_ev = make_events(1'b0, 1'b0, -200);
		iq_in = '0;
		iq_strobe = 1'b0;
		tsf_runtime_val = tsf_now;
		trig_sel = side_ch_pkg::FCS_GOOD;
		rssi_th = side_ch_pkg::rssi_t'(-100);
		gain_th = 7'd40;
		pre_trigger_len = ADDR_W'(PRE);
		iq_len_target = ADDR_W'(LEN);
		start_mode = 2'd0;
		ext_start = 1'b0;
		reg_wren = 1'b0;
		reg_waddr = '0;
		lb_data = '0;
		lb_valid = 1'b0;
		lb_last = 1'b0;
		m_axis_data_count = '0;
		repeat (10) @(posedge clk);
		rstn <= 1'b1;

		begin_test("loopback");
		for (i = 0; i < 6; i++) begin
			hold_cycle();
			lb_word = {$urandom, $urandom};
			lb_data <= lb_word;
			lb_valid <= (i != 2);
			lb_last <= (i == 5);
			if (i != 2)
				exp_q.push_back(lb_word);
			@(negedge clk);
			check_bit("pl_ask_data", 1'b1, pl_ask_data);
			check_bit("start pulse", (i == 5), m_axis_start_1trans);
		end
		hold_cycle();
		lb_valid <= 1'b0;
		lb_last <= 1'b0;
		start_mode <= 2'd1;
		wait_drain(10);
		end_test();

		begin_test("fcs_good");
		run_cycles(40);
		fire_event(make_events(1'b1, 1'b1, -200), 1'b1);
		wait_drain(200);
		end_test();

		begin_test("fcs_bad");
		hold_cycle();
		trig_sel <= side_ch_pkg::FCS_BAD;
		fire_event(make_events(1'b1, 1'b1, -200), 1'b0);
		run_cycles(100);
		fire_event(make_events(1'b1, 1'b0, -200), 1'b1);
		wait_drain(200);
		end_test();

		begin_test("rssi_rise");
		hold_cycle();
		trig_sel <= side_ch_pkg::RSSI_RISE;
		run_cycles(10);
		fire_event(make_events(1'b0, 1'b0, -50), 1'b1);
		wait_drain(200);
		fire_event(make_events(1'b0, 1'b0, -200), 1'b0); // falling step
		run_cycles(100);
		end_test();

		begin_test("back_pressure");
		hold_cycle();
		trig_sel <= side_ch_pkg::FCS_GOOD;
		m_axis_data_count <= CNT_W'(side_ch_pkg::UDP_MAX_SYMBOL - LEN); // one word short
		fire_event(make_events(1'b1, 1'b1, -200), 1'b0);
		run_cycles(100);
		hold_cycle();
		m_axis_data_count <= '0;
		fire_event(make_events(1'b1, 1'b1, -200), 1'b1);
		wait_drain(200);
		end_test();

		begin_test("auto_start");
		reg_write_check(5'd2, 1'b1);
		reg_write_check(5'd3, 1'b0);
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, err_count);
		if (err_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
